/* compile.f */
+incdir+design
design/ooo_pkg.sv
design/decoder.sv
design/id_stage.sv
design/free_list.sv
design/map_table.sv
design/rename_top.sv
testbench/rename_tb.sv

/* Makefile */
# Verilator build and run for the rename front end

VERILATOR ?= verilator
TOP       ?= rename_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/rename_tb.sv */
/*
  rename front end testbench
  drives decode and rename through rename_top, keeps its own map and
  free tag model, concurrent checks compare rn_out with the expected queue
*/
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module rename_tb;

  // expected flag bundle {rd, wr, ldl, stc, cond, uncond, cpuid}
  localparam logic [6:0] F_RD   = 7'b100_0000;
  localparam logic [6:0] F_WR   = 7'b010_0000;
  localparam logic [6:0] F_LDL  = 7'b001_0000;
  localparam logic [6:0] F_STC  = 7'b000_1000;
  localparam logic [6:0] F_COND = 7'b000_0100;
  localparam logic [6:0] F_UNC  = 7'b000_0010;
  localparam logic [6:0] F_CPU  = 7'b000_0001;

  logic                clock = 1'b0;
  logic                rst_n;
  logic [31:0]         inst;
  logic                inst_valid;
  logic                retire_valid;
  ooo_pkg::phys_tag_t  retire_tag;
  ooo_pkg::rn_packet_t rn_out;
  logic                stall;

  // reference model state
  ooo_pkg::phys_tag_t  map_m [`ARCH_REGS];
  ooo_pkg::phys_tag_t  fifo_m [$];        // free tags, head first
  ooo_pkg::phys_tag_t  stale_q [$];       // superseded tags, safe to retire
  ooo_pkg::rn_packet_t exp_mem [0:127];
  ooo_pkg::rn_packet_t exp_head;
  int                  wr_idx = 0;
  int                  rd_idx = 0;
  int                  errors = 0;
  int                  checked = 0;
  int                  test_no = 1;
  int                  err_mark = 0;
  logic [31:0]         lcg_state = 32'h4ef0;
  logic [6:0]          got_flags;
  logic [6:0]          exp_flags;
  logic [14:0]         got_idx;
  logic [14:0]         exp_idx;

  always #20 clock = ~clock;              // 40 ns period

  rename_top rename_top_i
  (
    .clock        (clock),
    .rst_n        (rst_n),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .rn_out       (rn_out),
    .stall        (stall)
  );

  //////////////////////////////////////////////////
  // output checks
  //////////////////////////////////////////////////
  assign exp_head  = exp_mem[rd_idx];
  assign got_flags = {rn_out.dec.rd_mem, rn_out.dec.wr_mem, rn_out.dec.ldl_mem,
                      rn_out.dec.stc_mem, rn_out.dec.cond_branch,
                      rn_out.dec.uncond_branch, rn_out.dec.cpuid};
  assign exp_flags = {exp_head.dec.rd_mem, exp_head.dec.wr_mem, exp_head.dec.ldl_mem,
                      exp_head.dec.stc_mem, exp_head.dec.cond_branch,
                      exp_head.dec.uncond_branch, exp_head.dec.cpuid};
  assign got_idx   = {rn_out.dec.ra_idx, rn_out.dec.rb_idx, rn_out.dec.rdest_idx};
  assign exp_idx   = {exp_head.dec.ra_idx, exp_head.dec.rb_idx, exp_head.dec.rdest_idx};

  // one entry consumed per renamed output
  always @(posedge clock)
  begin
    if (rst_n && rn_out.valid)
    begin
      rd_idx  <= rd_idx + 1;
      checked <= checked + 1;
    end
  end

  // sampled mid cycle, rn_out is settled by then
  a_pending: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rd_idx != wr_idx))
    else report_mismatch("rn_out.valid (nothing pending)", 1, 0);
  a_inst: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.dec.inst == exp_head.dec.inst))
    else report_mismatch("rn_out.dec.inst", rn_out.dec.inst, exp_head.dec.inst);
  a_func: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.dec.alu_func == exp_head.dec.alu_func))
    else report_mismatch("rn_out.dec.alu_func", rn_out.dec.alu_func, exp_head.dec.alu_func);
  a_fu: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.dec.fu_name == exp_head.dec.fu_name))
    else report_mismatch("rn_out.dec.fu_name", rn_out.dec.fu_name, exp_head.dec.fu_name);
  a_flags: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (got_flags == exp_flags))
    else report_mismatch("rn_out.dec flags", got_flags, exp_flags);
  a_idx: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (got_idx == exp_idx))
    else report_mismatch("rn_out.dec ra/rb/rdest idx", got_idx, exp_idx);
  a_pra: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.pra_tag == exp_head.pra_tag))
    else report_mismatch("rn_out.pra_tag", rn_out.pra_tag, exp_head.pra_tag);
  a_prb: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.prb_tag == exp_head.prb_tag))
    else report_mismatch("rn_out.prb_tag", rn_out.prb_tag, exp_head.prb_tag);
  a_prd: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.prd_tag == exp_head.prd_tag))
    else report_mismatch("rn_out.prd_tag", rn_out.prd_tag, exp_head.prd_tag);
  a_old: assert property (@(negedge clock) disable iff (!rst_n)
    rn_out.valid |-> (rn_out.old_prd_tag == exp_head.old_prd_tag))
    else report_mismatch("rn_out.old_prd_tag", rn_out.old_prd_tag, exp_head.old_prd_tag);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
  begin
    errors++;
    $display("ERROR %s: got %h expected %h", sig, got, want);
  end
  endtask

  function automatic ooo_pkg::arch_reg_t rand_reg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return ooo_pkg::arch_reg_t'(lcg_state[23:16] % 31);   // r0..r30
  endfunction

  function automatic logic [31:0] op_word(input logic [5:0] opc, input logic [4:0] ra,
                                          input logic [4:0] rb, input logic [6:0] func,
                                          input logic [4:0] rc);
    return {opc, ra, rb, 3'b000, 1'b0, func, rc};
  endfunction

  function automatic logic [31:0] imm_word(input logic [5:0] opc, input logic [4:0] ra,
                                           input logic [7:0] lit, input logic [6:0] func,
                                           input logic [4:0] rc);
    return {opc, ra, lit, 1'b1, func, rc};
  endfunction

  // expected packet from the encoding rules, tags from the model
  task automatic predict(input logic [31:0] word, input ooo_pkg::alu_func_e func,
                         input ooo_pkg::fu_name_e fu, input logic [6:0] flags,
                         input ooo_pkg::arch_reg_t ra_i, input ooo_pkg::arch_reg_t rb_i,
                         input ooo_pkg::arch_reg_t rd_i);
    ooo_pkg::rn_packet_t e;
  begin
    e              = '0;
    e.dec.inst     = word;
    e.dec.alu_func = func;
    e.dec.fu_name  = fu;
    {e.dec.rd_mem, e.dec.wr_mem, e.dec.ldl_mem, e.dec.stc_mem,
     e.dec.cond_branch, e.dec.uncond_branch, e.dec.cpuid} = flags;
    e.dec.ra_idx    = ra_i;
    e.dec.rb_idx    = rb_i;
    e.dec.rdest_idx = rd_i;
    e.pra_tag       = map_m[ra_i];
    e.prb_tag       = map_m[rb_i];
    e.old_prd_tag   = map_m[rd_i];
    e.prd_tag       = map_m[rd_i];           // r31 keeps tag 31
    if (rd_i != `ZERO_REG)
    begin
      e.prd_tag   = fifo_m.pop_front();
      map_m[rd_i] = e.prd_tag;
      if (e.old_prd_tag >= `ARCH_REGS)
        stale_q.push_back(e.old_prd_tag);
    end
    exp_mem[wr_idx] = e;
    wr_idx++;
  end
  endtask

  // hold word until the ID stage takes it
  task automatic drive(input logic [31:0] word);
    int   n;
    logic s;
  begin
    inst       <= word;
    inst_valid <= 1'b1;
    n = 0;
    do
    begin
      @(negedge clock);
      s = stall;
      @(posedge clock);
      n++;
    end while (s && n < 100);
    if (s)
    begin
      errors++;
      $display("instruction %h was never accepted, stall stayed high", word);
    end
  end
  endtask

  task automatic send(input logic [31:0] word, input ooo_pkg::alu_func_e func,
                      input ooo_pkg::fu_name_e fu, input logic [6:0] flags,
                      input ooo_pkg::arch_reg_t ra_i, input ooo_pkg::arch_reg_t rb_i,
                      input ooo_pkg::arch_reg_t rd_i);
  begin
    predict(word, func, fu, flags, ra_i, rb_i, rd_i);
    drive(word);
  end
  endtask

  task automatic idle();
  begin
    inst_valid <= 1'b0;
    inst       <= '0;
  end
  endtask

  task automatic wait_drain();
    int n;
  begin
    n = 0;
    do
    begin
      @(negedge clock);
      n++;
    end while (rd_idx != wr_idx && n < 50);
    if (rd_idx != wr_idx)
    begin
      errors++;
      $display("timed out waiting for %0d renamed outputs", wr_idx - rd_idx);
    end
    @(posedge clock);
  end
  endtask

  task automatic end_test(input string name);
  begin
    idle();
    wait_drain();
    $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
    test_no++;
    err_mark = errors;
  end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial
  begin : stim
    ooo_pkg::arch_reg_t a;
    ooo_pkg::arch_reg_t b;
    ooo_pkg::arch_reg_t d;
    ooo_pkg::phys_tag_t t;
    logic [31:0]        w;
    int                 k;

    rst_n        = 1'b0;
    inst         = '0;
    inst_valid   = 1'b0;
    retire_valid = 1'b0;
    retire_tag   = '0;
    for (k = 0; k < `ARCH_REGS; k++)
      map_m[k] = ooo_pkg::phys_tag_t'(k);      // identity
    for (k = `ARCH_REGS; k < `PHYS_REGS; k++)
      fifo_m.push_back(ooo_pkg::phys_tag_t'(k));

    repeat (10) @(posedge clock);
    rst_n <= 1'b1;

    // 1 quiet after reset
    @(negedge clock);
    assert (rn_out.valid === 1'b0) else report_mismatch("rn_out.valid", rn_out.valid, 0);
    assert (stall === 1'b0) else report_mismatch("stall", stall, 0);
    @(posedge clock);
    end_test("reset");

    // 2 decode of each group
    send(op_word(`INTA_GRP, 1, 2, `ADDQ_INST, 3), ooo_pkg::ALU_ADDQ, ooo_pkg::FU_ALU, '0, 1, 2, 3);
    send(imm_word(`INTA_GRP, 4, 8'h05, `SUBQ_INST, 5), ooo_pkg::ALU_SUBQ, ooo_pkg::FU_ALU,
         '0, 4, `ZERO_REG, 5);                // literal, rb unused
    send(op_word(`INTA_GRP, 6, 7, `CMPLT_INST, 8), ooo_pkg::ALU_CMPLT, ooo_pkg::FU_ALU,
         '0, 6, 7, 8);
    send(op_word(`INTL_GRP, 9, 10, `XOR_INST, 11), ooo_pkg::ALU_XOR, ooo_pkg::FU_ALU,
         '0, 9, 10, 11);
    send(imm_word(`INTS_GRP, 12, 8'h03, `SLL_INST, 13), ooo_pkg::ALU_SLL, ooo_pkg::FU_ALU,
         '0, 12, `ZERO_REG, 13);
    send(op_word(`INTM_GRP, 14, 15, `MULQ_INST, 16), ooo_pkg::ALU_MULQ, ooo_pkg::FU_MULT,
         '0, 14, 15, 16);
    // memory: base in rb, ra is data or dest
    send({`LDQ_INST, 5'd17, 5'd18, 16'h0010}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_LD, F_RD,
         `ZERO_REG, 18, 17);
    send({`STQ_INST, 5'd19, 5'd20, 16'h0018}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_LD, F_WR,
         19, 20, `ZERO_REG);
    send({`LDQ_L_INST, 5'd21, 5'd18, 16'h0020}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_LD,
         F_RD | F_LDL, `ZERO_REG, 18, 21);
    send({`STQ_C_INST, 5'd22, 5'd23, 16'h0028}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_LD,
         F_WR | F_STC, 22, 23, 22);
    // branches
    send({`BR_INST, 5'd26, 21'h00040}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_BR, F_UNC,
         26, `ZERO_REG, 26);
    send({6'h39, 5'd24, 21'h1ffff0}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_BR, F_COND,
         24, `ZERO_REG, `ZERO_REG);            // beq, no link
    send({`JSR_GRP, 5'd26, 5'd27, 16'h4000}, ooo_pkg::ALU_AND, ooo_pkg::FU_BR, F_UNC,
         26, 27, 26);
    end_test("decode");

    // 3 halt and illegal take nothing, cpuid writes r0
    drive({`PAL_INST, `PAL_HALT});
    drive(op_word(6'h16, 1, 2, 7'h20, 3));     // fp operate group
    drive(op_word(`INTA_GRP, 1, 2, 7'h7f, 3)); // unknown function code
    send({`PAL_INST, `PAL_WHAMI}, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_ALU, F_CPU, 0, 0, 0);
    end_test("halt/illegal/cpuid");

    // 4 dependent chain
    a = rand_reg();
    b = rand_reg();
    for (k = 0; k < 8; k++)
    begin
      d = rand_reg();
      w = op_word(`INTA_GRP, a, b, `ADDQ_INST, d);
      send(w, ooo_pkg::ALU_ADDQ, ooo_pkg::FU_ALU, '0, a, b, d);
      b = a;                                   // reads two back
      a = d;                                   // reads last dest
    end
    send(op_word(`INTA_GRP, a, b, `ADDQ_INST, `ZERO_REG), ooo_pkg::ALU_ADDQ, ooo_pkg::FU_ALU,
         '0, a, b, `ZERO_REG);
    send(op_word(`INTL_GRP, a, `ZERO_REG, `BIS_INST, b), ooo_pkg::ALU_BIS, ooo_pkg::FU_ALU,
         '0, a, `ZERO_REG, b);
    end_test("rename chain");

    // 5 drain free list, stall, retire one
    while (fifo_m.size() > 0)
      send(op_word(`INTL_GRP, 1, 2, `BIS_INST, 1), ooo_pkg::ALU_BIS, ooo_pkg::FU_ALU,
           '0, 1, 2, 1);
    w = op_word(`INTL_GRP, 3, 1, `AND_INST, 4);
    drive(w);
    idle();
    wait_drain();
    repeat (4)
    begin
      @(negedge clock);
      assert (stall === 1'b1) else report_mismatch("stall", stall, 1);
    end
    @(posedge clock);
    t = stale_q.pop_front();
    fifo_m.push_back(t);                       // model sees the release first
    predict(w, ooo_pkg::ALU_AND, ooo_pkg::FU_ALU, '0, 3, 1, 4);
    retire_tag   <= t;
    retire_valid <= 1'b1;
    @(posedge clock);
    retire_valid <= 1'b0;
    end_test("exhaust/release");

    $display("%0d tests, %0d outputs checked, %0d errors", test_no - 1, checked, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* design/rename_top.sv */
/*
  rename front end top
  decode stage into map table, free list feeding tags
*/
`timescale 1ns/10ps
`default_nettype none

module rename_top
(
  input  wire                 clock,
  input  wire                 rst_n,
  input  wire [31:0]          inst,
  input  wire                 inst_valid,
  input  wire                 retire_valid,
  input  wire ooo_pkg::phys_tag_t retire_tag,
  output ooo_pkg::rn_packet_t rn_out,
  output logic                stall          // source holds inst while high
);

  ooo_pkg::id_packet_t id_pkt;
  ooo_pkg::phys_tag_t  free_tag;
  logic                alloc_req;
  logic                empty;

  id_stage id_stage_i
  (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .stall      (stall),
    .id_pkt     (id_pkt)
  );

  map_table map_table_i
  (
    .clock     (clock),
    .rst_n     (rst_n),
    .id_pkt    (id_pkt),
    .free_tag  (free_tag),
    .empty     (empty),
    .alloc_req (alloc_req),
    .stall     (stall),
    .rn_out    (rn_out)
  );

  free_list free_list_i
  (
    .clock        (clock),
    .rst_n        (rst_n),
    .alloc_req    (alloc_req),
    .retire_valid (retire_valid),   // straight from retire
    .retire_tag   (retire_tag),
    .free_tag     (free_tag),
    .empty        (empty)
  );

endmodule

`default_nettype wire

/* design/map_table.sv */
/*
  register map table
  source and old dest lookup, dest rename, registered rn_out packet
*/
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module map_table
(
  input  wire                 clock,
  input  wire                 rst_n,
  input  wire ooo_pkg::id_packet_t id_pkt,
  input  wire ooo_pkg::phys_tag_t  free_tag,    // free list head
  input  wire                 empty,
  output logic                alloc_req,
  output logic                stall,
  output ooo_pkg::rn_packet_t rn_out
);

  ooo_pkg::phys_tag_t  map [`ARCH_REGS];
  ooo_pkg::rn_packet_t rn_next;
  ooo_pkg::rn_packet_t rn_hold;
  logic                rn_valid;
  logic                need_tag;
  logic                fire;

  // r31 never takes a tag
  assign need_tag  = id_pkt.valid && (id_pkt.rdest_idx != `ZERO_REG);
  assign stall     = need_tag && empty;
  assign alloc_req = need_tag && !empty;
  assign fire      = id_pkt.valid && !stall;

  //////////////////////////////////////////////////
  // lookup, same cycle as id_pkt
  //////////////////////////////////////////////////
  always_comb
  begin
    rn_next.valid       = fire;
    rn_next.dec         = id_pkt;
    rn_next.pra_tag     = map[id_pkt.ra_idx];
    rn_next.prb_tag     = map[id_pkt.rb_idx];
    rn_next.old_prd_tag = map[id_pkt.rdest_idx];
    rn_next.prd_tag     = need_tag ? free_tag : map[id_pkt.rdest_idx];
  end

  // map written on the edge the next inst enters lookup, so no bypass
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      for (int i = 0; i < `ARCH_REGS; i++)
        map[i] <= ooo_pkg::phys_tag_t'(i);  // identity
    else if (alloc_req)
      map[id_pkt.rdest_idx] <= free_tag;
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      rn_valid <= 1'b0;
    else
      rn_valid <= fire;
  end

  always_ff @(posedge clock)
  begin
    if (fire)
      rn_hold <= rn_next;
  end

  always_comb
  begin
    rn_out       = rn_hold;
    rn_out.valid = rn_valid;
  end

  a_zero_reg_fixed: assert property (@(posedge clock) disable iff (!rst_n)
    map[`ZERO_REG] == ooo_pkg::phys_tag_t'(`ZERO_REG))
    else $error("r31 mapping moved to %0h", map[`ZERO_REG]);

  a_stall_no_out: assert property (@(posedge clock) disable iff (!rst_n)
    stall |=> !rn_out.valid)
    else $error("rn_out.valid high after stall");

endmodule

`default_nettype wire

/* design/free_list.sv */
/*
  physical tag free list
  circular queue, pop at head on allocate, push at tail on retire
*/
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module free_list
(
  input  wire                clock,
  input  wire                rst_n,
  input  wire                alloc_req,     // pop head
  input  wire                retire_valid,  // push retire_tag
  input  wire ooo_pkg::phys_tag_t retire_tag,
  output ooo_pkg::phys_tag_t free_tag,
  output logic               empty
);

  localparam int PTR_W    = $clog2(`PHYS_REGS);
  localparam int FREE_MAX = `PHYS_REGS - `ARCH_REGS;   // arch state always holds the rest

  ooo_pkg::phys_tag_t queue [`PHYS_REGS];
  logic [PTR_W-1:0]   head;
  logic [PTR_W-1:0]   tail;
  logic [PTR_W:0]     count;

  //////////////////////////////////////////////////
  // queue state
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      head  <= '0;
      tail  <= PTR_W'(FREE_MAX);
      count <= (PTR_W+1)'(FREE_MAX);
      for (int i = 0; i < `PHYS_REGS; i++)
        queue[i] <= ooo_pkg::phys_tag_t'(i + `ARCH_REGS);  // 32..63 up front, upper half stale
    end
    else
    begin
      if (alloc_req)
        head <= head + 1'b1;
      if (retire_valid)
      begin
        queue[tail] <= retire_tag;        // visible at head from next cycle
        tail        <= tail + 1'b1;
      end
      count <= count + (PTR_W+1)'(retire_valid) - (PTR_W+1)'(alloc_req);
    end
  end

  assign free_tag = queue[head];
  assign empty    = (count == '0);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  a_no_alloc_empty: assert property (@(posedge clock) disable iff (!rst_n)
    alloc_req |-> !empty)
    else $error("allocate from empty free list");

  a_release_range: assert property (@(posedge clock) disable iff (!rst_n)
    retire_valid |-> (retire_tag >= `ARCH_REGS))
    else $error("released tag %0h below ARCH_REGS", retire_tag);

  a_count_limit: assert property (@(posedge clock) disable iff (!rst_n)
    count <= FREE_MAX)
    else $error("free count %0h over limit", count);

endmodule

`default_nettype wire

/* design/id_stage.sv */
/*
  decode stage
  decoder plus the id/rename pipeline register, held under stall
*/
`timescale 1ns/10ps
`default_nettype none

module id_stage
(
  input  wire                 clock,
  input  wire                 rst_n,
  input  wire [31:0]          inst,
  input  wire                 inst_valid,
  input  wire                 stall,       // from map table
  output ooo_pkg::id_packet_t id_pkt
);

  ooo_pkg::id_packet_t dec_pkt;
  ooo_pkg::id_packet_t hold_pkt;           // payload, no reset
  logic                hold_valid;

  decoder decoder_i
  (
    .inst          (inst),
    .valid_inst_in (inst_valid),
    .pkt           (dec_pkt)
  );

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      hold_valid <= 1'b0;
    else if (!stall)
      hold_valid <= dec_pkt.valid;
  end

  always_ff @(posedge clock)
  begin
    if (!stall)
      hold_pkt <= dec_pkt;
  end

  always_comb
  begin
    id_pkt       = hold_pkt;
    id_pkt.valid = hold_valid;             // controlled copy wins
  end

  // stalled instruction must wait in place for a tag
  a_hold_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
    stall |=> $stable(id_pkt))
    else $error("id_pkt changed while stalled");

endmodule

`default_nettype wire

/* design/decoder.sv */
/*
  alpha integer subset decoder
  combinational, inst bits in, datapath controls and reg indices out
*/
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module decoder
(
  input  wire [31:0]          inst,
  input  wire                 valid_inst_in,   // low means treat as noop
  output ooo_pkg::id_packet_t pkt
);

  ooo_pkg::dest_reg_sel_e dest_reg;

  always_comb
  begin
    // noop defaults, groups below override
    dest_reg           = ooo_pkg::DEST_NONE;
    pkt                = '0;
    pkt.inst           = inst;
    pkt.opa_select     = ooo_pkg::ALU_OPA_IS_REGA;
    pkt.opb_select     = ooo_pkg::ALU_OPB_IS_REGB;
    pkt.alu_func       = ooo_pkg::ALU_ADDQ;
    pkt.fu_name        = ooo_pkg::FU_ALU;

    if (valid_inst_in)
    begin
      case ({inst[31:29], 3'b0})
        6'h00:
        begin
          if (inst[31:26] != `PAL_INST)
            pkt.illegal = `TRUE;
          else if (inst[25:0] == `PAL_HALT)
            pkt.halt = `TRUE;
          else if (inst[25:0] == `PAL_WHAMI)
          begin
            pkt.cpuid = `TRUE;
            dest_reg  = ooo_pkg::DEST_IS_REGA;  // cpuid lands in ra
          end
          else
            pkt.illegal = `TRUE;
        end
        6'h10:
        begin
          pkt.opb_select = inst[12] ? ooo_pkg::ALU_OPB_IS_ALU_IMM : ooo_pkg::ALU_OPB_IS_REGB;
          dest_reg       = ooo_pkg::DEST_IS_REGC;
          case (inst[31:26])
            `INTA_GRP:
              case (inst[11:5])
                `ADDQ_INST:   pkt.alu_func = ooo_pkg::ALU_ADDQ;
                `SUBQ_INST:   pkt.alu_func = ooo_pkg::ALU_SUBQ;
                `CMPEQ_INST:  pkt.alu_func = ooo_pkg::ALU_CMPEQ;
                `CMPLT_INST:  pkt.alu_func = ooo_pkg::ALU_CMPLT;
                `CMPLE_INST:  pkt.alu_func = ooo_pkg::ALU_CMPLE;
                `CMPULT_INST: pkt.alu_func = ooo_pkg::ALU_CMPULT;
                `CMPULE_INST: pkt.alu_func = ooo_pkg::ALU_CMPULE;
                default:      pkt.illegal  = `TRUE;
              endcase
            `INTL_GRP:
              case (inst[11:5])
                `AND_INST:    pkt.alu_func = ooo_pkg::ALU_AND;
                `BIC_INST:    pkt.alu_func = ooo_pkg::ALU_BIC;
                `BIS_INST:    pkt.alu_func = ooo_pkg::ALU_BIS;
                `ORNOT_INST:  pkt.alu_func = ooo_pkg::ALU_ORNOT;
                `XOR_INST:    pkt.alu_func = ooo_pkg::ALU_XOR;
                `EQV_INST:    pkt.alu_func = ooo_pkg::ALU_EQV;
                default:      pkt.illegal  = `TRUE;
              endcase
            `INTS_GRP:
              case (inst[11:5])
                `SRL_INST:    pkt.alu_func = ooo_pkg::ALU_SRL;
                `SLL_INST:    pkt.alu_func = ooo_pkg::ALU_SLL;
                `SRA_INST:    pkt.alu_func = ooo_pkg::ALU_SRA;
                default:      pkt.illegal  = `TRUE;
              endcase
            `INTM_GRP:
            begin
              pkt.fu_name = ooo_pkg::FU_MULT;
              if (inst[11:5] == `MULQ_INST)
                pkt.alu_func = ooo_pkg::ALU_MULQ;
              else
                pkt.illegal = `TRUE;
            end
            default: pkt.illegal = `TRUE;      // itfp and fp operate groups
          endcase
        end
        6'h18:
        begin
          if (inst[31:26] == `JSR_GRP)
          begin
            // jmp, jsr, ret, jsr_co all behave alike
            pkt.fu_name       = ooo_pkg::FU_BR;
            pkt.opa_select    = ooo_pkg::ALU_OPA_IS_NOT3;
            pkt.alu_func      = ooo_pkg::ALU_AND;   // word align target
            pkt.uncond_branch = `TRUE;
            dest_reg          = ooo_pkg::DEST_IS_REGA;
          end
          else
            pkt.illegal = `TRUE;                  // misc, ftpi
        end
        6'h08, 6'h20, 6'h28:
        begin
          pkt.opa_select = ooo_pkg::ALU_OPA_IS_MEM_DISP;
          pkt.fu_name    = ooo_pkg::FU_LD;
          dest_reg       = ooo_pkg::DEST_IS_REGA;
          case (inst[31:26])
            `LDA_INST:   ;                         // address add only
            `LDQ_INST:   pkt.rd_mem = `TRUE;
            `LDQ_L_INST:
            begin
              pkt.rd_mem  = `TRUE;
              pkt.ldl_mem = `TRUE;
            end
            `STQ_INST:
            begin
              pkt.wr_mem = `TRUE;
              dest_reg   = ooo_pkg::DEST_NONE;
            end
            `STQ_C_INST:
            begin
              pkt.wr_mem  = `TRUE;
              pkt.stc_mem = `TRUE;                 // success flag back to ra
            end
            default: pkt.illegal = `TRUE;
          endcase
        end
        6'h30, 6'h38:
        begin
          pkt.opa_select = ooo_pkg::ALU_OPA_IS_NPC;
          pkt.opb_select = ooo_pkg::ALU_OPB_IS_BR_DISP;
          pkt.fu_name    = ooo_pkg::FU_BR;
          case (inst[31:26])
            `BR_INST, `BSR_INST:
            begin
              pkt.uncond_branch = `TRUE;
              dest_reg          = ooo_pkg::DEST_IS_REGA;   // link reg
            end
            default:
              if (inst[31:29] == 3'b110)
                pkt.illegal = `TRUE;               // fp branches
              else
                pkt.cond_branch = `TRUE;
          endcase
        end
        default: pkt.illegal = `TRUE;
      endcase
    end

    // index steering, unused ports point at r31
    // store data comes from ra as well
    pkt.ra_idx = ((pkt.opa_select == ooo_pkg::ALU_OPA_IS_REGA) ||
                  (pkt.fu_name == ooo_pkg::FU_BR) || pkt.wr_mem) ? inst[25:21] : `ZERO_REG;
    pkt.rb_idx = (pkt.opb_select == ooo_pkg::ALU_OPB_IS_REGB) ? inst[20:16] : `ZERO_REG;
    case (dest_reg)
      ooo_pkg::DEST_IS_REGC: pkt.rdest_idx = inst[4:0];
      ooo_pkg::DEST_IS_REGA: pkt.rdest_idx = inst[25:21];
      default:               pkt.rdest_idx = `ZERO_REG;
    endcase

    pkt.valid = valid_inst_in && !pkt.illegal && !pkt.halt;   // halt dies here
  end

endmodule

`default_nettype wire

/* design/ooo_pkg.sv */
/*
  ooo front end types
  datapath control enums and the packets handed between stages
*/
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

  //////////////////////////////////////////////////
  // control selects
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    ALU_OPA_IS_REGA, ALU_OPA_IS_MEM_DISP, ALU_OPA_IS_NPC, ALU_OPA_IS_NOT3
  } alu_opa_select_e;

  typedef enum logic [2:0] {
    ALU_OPB_IS_REGB, ALU_OPB_IS_ALU_IMM, ALU_OPB_IS_BR_DISP
  } alu_opb_select_e;

  typedef enum logic [1:0] {DEST_NONE, DEST_IS_REGA, DEST_IS_REGC} dest_reg_sel_e;

  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
  } alu_func_e;

  typedef enum logic [1:0] {FU_ALU, FU_MULT, FU_LD, FU_BR} fu_name_e;

  typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;   // 5 bit
  typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;   // 6 bit

  //////////////////////////////////////////////////
  // stage packets
  //////////////////////////////////////////////////
  typedef struct packed {
    logic            valid;        // low for halt, illegal, bubble
    logic [31:0]     inst;
    alu_opa_select_e opa_select;
    alu_opb_select_e opb_select;
    alu_func_e       alu_func;
    fu_name_e        fu_name;
    logic            rd_mem;
    logic            wr_mem;
    logic            ldl_mem;      // load locked
    logic            stc_mem;      // store conditional
    logic            cond_branch;
    logic            uncond_branch;
    logic            halt;
    logic            cpuid;
    logic            illegal;
    arch_reg_t       ra_idx;
    arch_reg_t       rb_idx;
    arch_reg_t       rdest_idx;    // ZERO_REG when nothing written
  } id_packet_t;

  typedef struct packed {
    logic       valid;             // renamed this cycle
    id_packet_t dec;
    phys_tag_t  pra_tag;
    phys_tag_t  prb_tag;
    phys_tag_t  prd_tag;
    phys_tag_t  old_prd_tag;       // returned to free list at retire
  } rn_packet_t;

endpackage

`default_nettype wire

/* design/ooo_defs.svh */
/*
  ooo front end defines
  alpha encodings, register counts, common constants
*/
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

`define TRUE       1'b1
`define FALSE      1'b0

`define ARCH_REGS  32         // architectural integer regs
`define PHYS_REGS  64         // physical tags, 6 bit
`define ZERO_REG   5'd31      // r31 reads as zero, never renamed

// primary opcodes, inst[31:26]
`define PAL_INST   6'h00
`define LDA_INST   6'h08
`define INTA_GRP   6'h10
`define INTL_GRP   6'h11
`define INTS_GRP   6'h12
`define INTM_GRP   6'h13
`define JSR_GRP    6'h1a
`define LDQ_INST   6'h29
`define LDQ_L_INST 6'h2b
`define STQ_INST   6'h2d
`define STQ_C_INST 6'h2f
`define BR_INST    6'h30
`define BSR_INST   6'h34

// operate function codes, inst[11:5]
`define ADDQ_INST   7'h20
`define SUBQ_INST   7'h29
`define CMPULT_INST 7'h1d
`define CMPEQ_INST  7'h2d
`define CMPULE_INST 7'h3d
`define CMPLT_INST  7'h4d
`define CMPLE_INST  7'h6d
`define AND_INST    7'h00
`define BIC_INST    7'h08
`define BIS_INST    7'h20
`define ORNOT_INST  7'h28
`define XOR_INST    7'h40
`define EQV_INST    7'h48
`define SRL_INST    7'h34
`define SLL_INST    7'h39
`define SRA_INST    7'h3c
`define MULQ_INST   7'h20

// pal function field, inst[25:0]
`define PAL_HALT    26'h555
`define PAL_WHAMI   26'h3c

`endif
